// ==== source/icache_pkg.sv ====
// Instruction cache geometry constants and the lookup FSM state type
package icache_pkg;

  // Physical address and fetch word widths
  localparam int unsigned ADDR_WIDTH = 32;
  localparam int unsigned WORD_WIDTH = 64;

  // Direct-mapped organisation
  localparam int unsigned LINE_WORDS = 4;
  localparam int unsigned NUM_SETS   = 8;

  // Byte offset inside one 64-bit word
  localparam int unsigned BYTE_BITS = $clog2(WORD_WIDTH / 8);

  // Address split above the byte offset
  localparam int unsigned OFFSET_BITS = $clog2(LINE_WORDS);
  localparam int unsigned INDEX_BITS  = $clog2(NUM_SETS);
  localparam int unsigned TAG_BITS    = ADDR_WIDTH - INDEX_BITS - OFFSET_BITS - BYTE_BITS;

  // Lookup FSM
  typedef enum logic [1:0] {
    LK_IDLE,
    LK_COMPARE,
    LK_REFILL,
    LK_FLUSH
  } lookup_state_e;

endpackage

// ==== source/refill_pkg.sv ====
// Memory bus refill constants, noncacheable region and refill kind type
package refill_pkg;

  // Burst length is the beat count minus one
  localparam int unsigned BLEN_WIDTH = 2;

  // Addresses with this bit set are never cached
  localparam int unsigned NC_REGION_BIT = 31;

  // Opcode of a miss: whole line or a single bypassed word
  typedef enum logic {
    REFILL_LINE,
    REFILL_WORD
  } refill_kind_e;

endpackage

// ==== source/fetch_decode.sv ====
// Fetch decode stage: registers a fetch, splits the address, classifies cacheability
`timescale 1ns/1ps

module fetch_decode
  import icache_pkg::*;
  import refill_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   fetch_req_i,
  input  logic [ADDR_WIDTH-1:0]  fetch_addr_i,
  input  logic                   en_i,
  output logic                   dec_valid_o,
  output logic [TAG_BITS-1:0]    dec_tag_o,
  output logic [INDEX_BITS-1:0]  dec_index_o,
  output logic [OFFSET_BITS-1:0] dec_offset_o,
  output refill_kind_e           dec_kind_o
);

  logic                  dec_valid_q;
  logic [ADDR_WIDTH-1:0] addr_q;
  refill_kind_e          kind_q;
  refill_kind_e          kind_d;

  // Bypass everything while the cache is off or the address is in the IO region
  assign kind_d = (!en_i || fetch_addr_i[NC_REGION_BIT]) ? REFILL_WORD : REFILL_LINE;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dec_valid_q <= 1'b0;
    end else begin
      dec_valid_q <= fetch_req_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (fetch_req_i) begin
      addr_q <= fetch_addr_i;
      kind_q <= kind_d;
    end
  end

  assign dec_valid_o  = dec_valid_q;
  assign dec_kind_o   = kind_q;

  // Tag | index | word offset | byte offset
  assign dec_tag_o    = addr_q[ADDR_WIDTH-1 -: TAG_BITS];
  assign dec_index_o  = addr_q[BYTE_BITS+OFFSET_BITS +: INDEX_BITS];
  assign dec_offset_o = addr_q[BYTE_BITS +: OFFSET_BITS];

endmodule

// ==== source/icache_lookup.sv ====
// Cache arrays, hit compare, miss FSM, flush handling and fetch response
`timescale 1ns/1ps

module icache_lookup
  import icache_pkg::*;
  import refill_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  flush_i,
  input  logic                                  dec_valid_i,
  input  logic [TAG_BITS-1:0]                   dec_tag_i,
  input  logic [INDEX_BITS-1:0]                 dec_index_i,
  input  logic [OFFSET_BITS-1:0]                dec_offset_i,
  input  refill_kind_e                          dec_kind_i,
  input  logic                                  line_valid_i,
  input  logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_data_i,
  output logic                                  fetch_ready_o,
  output logic                                  fetch_valid_o,
  output logic                                  fetch_hit_o,
  output logic [WORD_WIDTH-1:0]                 fetch_data_o,
  output logic                                  miss_o,
  output logic                                  miss_valid_o,
  output logic [ADDR_WIDTH-1:0]                 miss_addr_o,
  output refill_kind_e                          miss_kind_o
);

  lookup_state_e state_q;
  lookup_state_e state_d;

  // Cache arrays
  logic [NUM_SETS-1:0]                   valid_q;
  logic [TAG_BITS-1:0]                   tag_q  [NUM_SETS];
  logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] data_q [NUM_SETS];

  // Request under lookup
  logic [TAG_BITS-1:0]    req_tag_q;
  logic [INDEX_BITS-1:0]  req_index_q;
  logic [OFFSET_BITS-1:0] req_offset_q;
  refill_kind_e           req_kind_q;

  logic                  fetch_valid_q;
  logic                  fetch_hit_q;
  logic [WORD_WIDTH-1:0] fetch_data_q;
  logic                  miss_q;

  logic hit;
  logic refill_done;
  logic line_write;

  // Bypassed words never hit, even if the line happens to be present
  assign hit = valid_q[req_index_q] && (tag_q[req_index_q] == req_tag_q) &&
               (req_kind_q == REFILL_LINE);

  assign refill_done = (state_q == LK_REFILL) && line_valid_i;
  assign line_write  = refill_done && (req_kind_q == REFILL_LINE);

  // Idle with nothing waiting in decode
  assign fetch_ready_o = (state_q == LK_IDLE) && !dec_valid_i;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      LK_IDLE: begin
        if (dec_valid_i) begin
          state_d = LK_COMPARE;
        end else if (flush_i) begin
          state_d = LK_FLUSH;
        end
      end
      LK_COMPARE: begin
        state_d = hit ? LK_IDLE : LK_REFILL;
      end
      LK_REFILL: begin
        if (line_valid_i) begin
          state_d = LK_IDLE;
        end
      end
      LK_FLUSH: begin
        state_d = LK_IDLE;
      end
      default: begin
        state_d = LK_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q       <= LK_IDLE;
      valid_q       <= '0;
      fetch_valid_q <= 1'b0;
      miss_q        <= 1'b0;
    end else begin
      state_q       <= state_d;
      fetch_valid_q <= ((state_q == LK_COMPARE) && hit) || refill_done;
      // One pulse per miss, also starts the bus request
      miss_q        <= (state_q == LK_COMPARE) && !hit;
      if (state_q == LK_FLUSH) begin
        valid_q <= '0;
      end else if (line_write) begin
        valid_q[req_index_q] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if ((state_q == LK_IDLE) && dec_valid_i) begin
      req_tag_q    <= dec_tag_i;
      req_index_q  <= dec_index_i;
      req_offset_q <= dec_offset_i;
      req_kind_q   <= dec_kind_i;
    end
    if (line_write) begin
      tag_q[req_index_q]  <= req_tag_q;
      data_q[req_index_q] <= line_data_i;
    end
    if (state_q == LK_COMPARE) begin
      fetch_hit_q  <= hit;
      fetch_data_q <= data_q[req_index_q][req_offset_q];
    end else if (refill_done) begin
      fetch_hit_q <= 1'b0;
      // A single word always arrives at offset 0
      if (req_kind_q == REFILL_LINE) begin
        fetch_data_q <= line_data_i[req_offset_q];
      end else begin
        fetch_data_q <= line_data_i[0];
      end
    end
  end

  assign fetch_valid_o = fetch_valid_q;
  assign fetch_hit_o   = fetch_hit_q;
  assign fetch_data_o  = fetch_data_q;

  assign miss_o       = miss_q;
  assign miss_valid_o = miss_q;
  assign miss_addr_o  = {req_tag_q, req_index_q, req_offset_q, {BYTE_BITS{1'b0}}};
  assign miss_kind_o  = req_kind_q;

endmodule

// ==== source/refill_request.sv ====
// Bus request holder that keeps a miss request stable until grant and picks the burst length
`timescale 1ns/1ps

module refill_request
  import icache_pkg::*;
  import refill_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  miss_valid_i,
  input  logic [ADDR_WIDTH-1:0] miss_addr_i,
  input  refill_kind_e          miss_kind_i,
  input  logic                  rd_gnt_i,
  output logic                  rd_req_o,
  output logic [ADDR_WIDTH-1:0] rd_addr_o,
  output logic [BLEN_WIDTH-1:0] rd_blen_o
);

  logic                  req_valid_q;
  logic                  req_valid_d;
  logic [ADDR_WIDTH-1:0] addr_q;
  logic [ADDR_WIDTH-1:0] addr_d;
  logic [BLEN_WIDTH-1:0] blen_q;
  logic [BLEN_WIDTH-1:0] blen_d;

  // Request stays up from the miss pulse until a grant is seen
  assign rd_req_o    = miss_valid_i | req_valid_q;
  assign req_valid_d = rd_req_o & ~rd_gnt_i;

  always_comb begin
    addr_d = addr_q;
    blen_d = blen_q;
    if (miss_valid_i) begin
      if (miss_kind_i == REFILL_LINE) begin
        // Line bursts start at the line base
        addr_d = {miss_addr_i[ADDR_WIDTH-1:OFFSET_BITS+BYTE_BITS],
                  {(OFFSET_BITS+BYTE_BITS){1'b0}}};
        blen_d = BLEN_WIDTH'(LINE_WORDS - 1);
      end else begin
        addr_d = miss_addr_i;
        blen_d = '0;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      req_valid_q <= 1'b0;
    end else begin
      req_valid_q <= req_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    addr_q <= addr_d;
    blen_q <= blen_d;
  end

  assign rd_addr_o = addr_d;
  assign rd_blen_o = blen_d;

endmodule

// ==== source/refill_assembler.sv ====
// Read data assembler: shifts burst beats into a cache line
`timescale 1ns/1ps

module refill_assembler
  import icache_pkg::*;
(
  input  logic                                  clk_i,
  input  logic                                  rst_ni,
  input  logic                                  rd_valid_i,
  input  logic                                  rd_last_i,
  input  logic [WORD_WIDTH-1:0]                 rd_data_i,
  output logic                                  line_valid_o,
  output logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_data_o
);

  logic                                  first_q;
  logic                                  first_d;
  logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] shift_q;
  logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] shift_d;

  always_comb begin
    first_d = first_q;
    shift_d = shift_q;
    if (rd_valid_i) begin
      // The beat after a last beat opens the next burst
      first_d = rd_last_i;
      shift_d = {rd_data_i, shift_q[LINE_WORDS-1:1]};
      // Single-beat burst: the word belongs at offset 0
      if (first_q && rd_last_i) begin
        shift_d[0] = rd_data_i;
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      first_q <= 1'b1;
    end else begin
      first_q <= first_d;
    end
  end

  always_ff @(posedge clk_i) begin
    shift_q <= shift_d;
  end

  // Line is complete together with the last beat
  assign line_valid_o = rd_valid_i & rd_last_i;
  assign line_data_o  = shift_d;

endmodule

// ==== source/icache_refill_top.sv ====
// Instruction cache refill subsystem top level: decode, lookup, bus request, assembler
`timescale 1ns/1ps

module icache_refill_top
  import icache_pkg::*;
  import refill_pkg::*;
(
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  en_i,
  input  logic                  flush_i,
  input  logic                  fetch_req_i,
  input  logic [ADDR_WIDTH-1:0] fetch_addr_i,
  input  logic                  rd_gnt_i,
  input  logic                  rd_valid_i,
  input  logic                  rd_last_i,
  input  logic [WORD_WIDTH-1:0] rd_data_i,
  output logic                  fetch_ready_o,
  output logic                  fetch_valid_o,
  output logic                  fetch_hit_o,
  output logic [WORD_WIDTH-1:0] fetch_data_o,
  output logic                  miss_o,
  output logic                  rd_req_o,
  output logic [ADDR_WIDTH-1:0] rd_addr_o,
  output logic [BLEN_WIDTH-1:0] rd_blen_o
);

  // Decode to lookup
  logic                   dec_valid;
  logic [TAG_BITS-1:0]    dec_tag;
  logic [INDEX_BITS-1:0]  dec_index;
  logic [OFFSET_BITS-1:0] dec_offset;
  refill_kind_e           dec_kind;

  // Lookup to bus request
  logic                  miss_valid;
  logic [ADDR_WIDTH-1:0] miss_addr;
  refill_kind_e          miss_kind;

  // Assembler to lookup
  logic                                  line_valid;
  logic [LINE_WORDS-1:0][WORD_WIDTH-1:0] line_data;

  fetch_decode fetch_decode_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .fetch_req_i  (fetch_req_i),
    .fetch_addr_i (fetch_addr_i),
    .en_i         (en_i),
    .dec_valid_o  (dec_valid),
    .dec_tag_o    (dec_tag),
    .dec_index_o  (dec_index),
    .dec_offset_o (dec_offset),
    .dec_kind_o   (dec_kind)
  );

  icache_lookup icache_lookup_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .flush_i       (flush_i),
    .dec_valid_i   (dec_valid),
    .dec_tag_i     (dec_tag),
    .dec_index_i   (dec_index),
    .dec_offset_i  (dec_offset),
    .dec_kind_i    (dec_kind),
    .line_valid_i  (line_valid),
    .line_data_i   (line_data),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_hit_o   (fetch_hit_o),
    .fetch_data_o  (fetch_data_o),
    .miss_o        (miss_o),
    .miss_valid_o  (miss_valid),
    .miss_addr_o   (miss_addr),
    .miss_kind_o   (miss_kind)
  );

  refill_request refill_request_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .miss_valid_i (miss_valid),
    .miss_addr_i  (miss_addr),
    .miss_kind_i  (miss_kind),
    .rd_gnt_i     (rd_gnt_i),
    .rd_req_o     (rd_req_o),
    .rd_addr_o    (rd_addr_o),
    .rd_blen_o    (rd_blen_o)
  );

  refill_assembler refill_assembler_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rd_valid_i   (rd_valid_i),
    .rd_last_i    (rd_last_i),
    .rd_data_i    (rd_data_i),
    .line_valid_o (line_valid),
    .line_data_o  (line_data)
  );

endmodule

// ==== testbench/tb_icache_refill.sv ====
// Testbench for the instruction cache refill subsystem with memory model, file stimulus and checks
`timescale 1ns/1ps

module tb_icache_refill
  import icache_pkg::*;
  import refill_pkg::*;
();

  localparam int HALF_PERIOD     = 20;
  localparam int CYCLES_PER_TEST = 200;
  localparam int RESPONSE_LIMIT  = 150;
  localparam     DATA_FILE       = "testbench/icache_testdata.txt";

  logic                  clk_i;
  logic                  rst_ni;
  logic                  en_i;
  logic                  flush_i;
  logic                  fetch_req_i;
  logic [ADDR_WIDTH-1:0] fetch_addr_i;
  logic                  rd_gnt_i;
  logic                  rd_valid_i;
  logic                  rd_last_i;
  logic [WORD_WIDTH-1:0] rd_data_i;
  logic                  fetch_ready_o;
  logic                  fetch_valid_o;
  logic                  fetch_hit_o;
  logic [WORD_WIDTH-1:0] fetch_data_o;
  logic                  miss_o;
  logic                  rd_req_o;
  logic [ADDR_WIDTH-1:0] rd_addr_o;
  logic [BLEN_WIDTH-1:0] rd_blen_o;

  // Stimulus loaded from the data file
  logic [7:0]  test_ops[$];
  logic [31:0] test_values[$];
  logic        test_hits[$];
  int          num_tests = 0;

  int tests_run    = 0;
  int test_errors  = 0;
  int failed_tests = 0;
  int total_errors = 0;

  logic [31:0] rng_state = 32'hf97f;

  // Every burst seen by the memory model
  logic [ADDR_WIDTH-1:0] burst_addrs[$];
  logic [BLEN_WIDTH-1:0] burst_blens[$];

  icache_refill_top icache_refill_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .en_i          (en_i),
    .flush_i       (flush_i),
    .fetch_req_i   (fetch_req_i),
    .fetch_addr_i  (fetch_addr_i),
    .rd_gnt_i      (rd_gnt_i),
    .rd_valid_i    (rd_valid_i),
    .rd_last_i     (rd_last_i),
    .rd_data_i     (rd_data_i),
    .fetch_ready_o (fetch_ready_o),
    .fetch_valid_o (fetch_valid_o),
    .fetch_hit_o   (fetch_hit_o),
    .fetch_data_o  (fetch_data_o),
    .miss_o        (miss_o),
    .rd_req_o      (rd_req_o),
    .rd_addr_o     (rd_addr_o),
    .rd_blen_o     (rd_blen_o)
  );

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return {16'h0000, rng_state[31:16]};
  endfunction

  // Upper half is the inverted address, lower half the address itself
  function automatic logic [WORD_WIDTH-1:0] memory_word(input logic [ADDR_WIDTH-1:0] addr);
    return {~addr, addr};
  endfunction

  task automatic check_equal(input string name, input logic [63:0] got, input logic [63:0] exp);
    assert (got === exp)
    else begin
      $display("FAILED %s: got 0x%h, expected 0x%h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic check_true(input logic cond, input string what);
    assert (cond === 1'b1)
    else begin
      $display("Error: %s", what);
      test_errors++;
    end
  endtask

  task automatic load_tests();
    int          fd;
    int          fields;
    string       line;
    logic [7:0]  op;
    logic [31:0] value;
    logic [31:0] hit_flag;
    fd = $fopen(DATA_FILE, "r");
    if (fd == 0) begin
      $display("Cannot open %s", DATA_FILE);
    end else begin
      while ($fgets(line, fd) != 0) begin
        // Skip comments and blank lines
        if (line.len() >= 2 && line[0] != "/") begin
          fields = $sscanf(line, "%c %h %h", op, value, hit_flag);
          if (fields == 3) begin
            test_ops.push_back(op);
            test_values.push_back(value);
            test_hits.push_back(hit_flag[0]);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic finish_test(input string desc);
    tests_run++;
    total_errors += test_errors;
    if (test_errors == 0) begin
      $display("[%0d] %s passed", tests_run, desc);
    end else begin
      failed_tests++;
      $display("[%0d] %s failed with %0d error(s)", tests_run, desc, test_errors);
    end
  endtask

  task automatic run_fetch(input logic [ADDR_WIDTH-1:0] addr, input logic exp_hit);
    int                    cycles;
    int                    misses;
    int                    bursts_before;
    logic                  responded;
    logic                  cacheable;
    logic [ADDR_WIDTH-1:0] exp_burst_addr;
    logic [BLEN_WIDTH-1:0] exp_blen;
    cacheable = en_i && !addr[NC_REGION_BIT];
    // Lines are 32 bytes and single words go to the exact address
    exp_burst_addr = cacheable ? {addr[ADDR_WIDTH-1:5], 5'b00000} : addr;
    // Four beats for a line, one beat for a word
    exp_blen       = cacheable ? 2'd3 : 2'd0;
    while (!fetch_ready_o) begin
      @(negedge clk_i);
    end
    bursts_before = burst_addrs.size();
    fetch_req_i   = 1'b1;
    fetch_addr_i  = addr;
    cycles        = 0;
    misses        = 0;
    responded     = 1'b0;
    while (!responded && cycles < RESPONSE_LIMIT) begin
      @(negedge clk_i);
      cycles++;
      fetch_req_i = 1'b0;
      if (miss_o) begin
        misses++;
      end
      if (fetch_valid_o) begin
        responded = 1'b1;
      end else begin
        check_true(!fetch_ready_o, "fetch_ready_o went high while a fetch was pending");
      end
    end
    check_true(responded, $sformatf("no response to fetch at 0x%h within %0d cycles",
                                    addr, RESPONSE_LIMIT));
    if (responded) begin
      check_equal("fetch_hit_o", 64'(fetch_hit_o), 64'(exp_hit));
      check_equal("fetch_data_o", fetch_data_o, memory_word(addr));
      check_equal("miss_o pulses", 64'(misses), 64'(exp_hit ? 0 : 1));
      check_equal("rd_req_o bursts", 64'(burst_addrs.size() - bursts_before),
                  64'(exp_hit ? 0 : 1));
      if (exp_hit) begin
        // Request edge to result edge
        check_equal("hit latency", 64'(cycles - 1), 64'd2);
      end else if (burst_addrs.size() > bursts_before) begin
        check_equal("rd_addr_o", 64'(burst_addrs[bursts_before]), 64'(exp_burst_addr));
        check_equal("rd_blen_o", 64'(burst_blens[bursts_before]), 64'(exp_blen));
      end
    end
  endtask

  task automatic run_flush();
    while (!fetch_ready_o) begin
      @(negedge clk_i);
    end
    flush_i = 1'b1;
    @(negedge clk_i);
    flush_i = 1'b0;
    check_equal("fetch_ready_o", 64'(fetch_ready_o), 64'd0);
    @(negedge clk_i);
    check_equal("fetch_ready_o", 64'(fetch_ready_o), 64'd1);
  endtask

  task automatic set_enable(input logic level);
    en_i = level;
    @(negedge clk_i);
  endtask

  initial begin : clock_gen
    clk_i = 1'b0;
    forever begin
      #HALF_PERIOD clk_i = ~clk_i;
    end
  end

  // Memory model with a random grant delay and random gaps between beats
  initial begin : memory_model
    logic [ADDR_WIDTH-1:0] req_addr;
    logic [BLEN_WIDTH-1:0] req_blen;
    int                    gnt_delay;
    int                    gap;
    forever begin
      @(negedge clk_i);
      if (rst_ni && rd_req_o === 1'b1) begin
        req_addr = rd_addr_o;
        req_blen = rd_blen_o;
        burst_addrs.push_back(req_addr);
        burst_blens.push_back(req_blen);
        gnt_delay = next_random() % 4;
        repeat (gnt_delay) begin
          @(negedge clk_i);
          check_true(rd_req_o && rd_addr_o == req_addr && rd_blen_o == req_blen,
                     "read request dropped or changed before the grant");
        end
        rd_gnt_i = 1'b1;
        @(negedge clk_i);
        rd_gnt_i = 1'b0;
        check_true(!rd_req_o, "rd_req_o still high after the grant");
        for (int beat = 0; beat <= int'(req_blen); beat++) begin
          gap = next_random() % 3;
          repeat (gap) @(negedge clk_i);
          rd_valid_i = 1'b1;
          rd_last_i  = (beat == int'(req_blen));
          rd_data_i  = memory_word(req_addr + ADDR_WIDTH'(beat * 8));
          @(negedge clk_i);
          rd_valid_i = 1'b0;
          rd_last_i  = 1'b0;
        end
      end
    end
  end

  initial begin : watchdog
    wait (num_tests != 0);
    repeat ((num_tests + 1) * CYCLES_PER_TEST) @(posedge clk_i);
    $display("Timeout: run did not complete within %0d cycles",
             (num_tests + 1) * CYCLES_PER_TEST);
    $display("TEST FAILED");
    $finish;
  end

  initial begin : stimulus
    string desc;
    rst_ni       = 1'b0;
    en_i         = 1'b1;
    flush_i      = 1'b0;
    fetch_req_i  = 1'b0;
    fetch_addr_i = '0;
    rd_gnt_i     = 1'b0;
    rd_valid_i   = 1'b0;
    rd_last_i    = 1'b0;
    rd_data_i    = '0;
    load_tests();
    num_tests = test_ops.size();
    if (num_tests == 0) begin
      $display("No tests found in %s", DATA_FILE);
      $display("TEST FAILED");
      $finish;
    end else begin
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_equal("fetch_ready_o", 64'(fetch_ready_o), 64'd1);
      check_equal("fetch_valid_o", 64'(fetch_valid_o), 64'd0);
      check_equal("miss_o", 64'(miss_o), 64'd0);
      check_equal("rd_req_o", 64'(rd_req_o), 64'd0);
      finish_test("state after reset");
      for (int i = 0; i < num_tests; i++) begin
        test_errors = 0;
        case (test_ops[i])
          "F": begin
            desc = $sformatf("fetch 0x%h expecting %s", test_values[i],
                             test_hits[i] ? "hit" : "miss");
            run_fetch(test_values[i], test_hits[i]);
          end
          "X": begin
            desc = "flush";
            run_flush();
          end
          "E": begin
            desc = $sformatf("enable %0d", test_values[i][0]);
            set_enable(test_values[i][0]);
          end
          default: begin
            desc = "unknown operation";
            check_true(1'b0, $sformatf("unknown operation '%c' in data file", test_ops[i]));
          end
        endcase
        finish_test(desc);
      end
      $display("Summary: %0d tests run, %0d failed, %0d errors",
               tests_run, failed_tests, total_errors);
      if (failed_tests == 0) begin
        $display("TEST OK");
      end else begin
        $display("TEST FAILED");
      end
      $finish;
    end
  end

endmodule

// ==== files.f ====
source/icache_pkg.sv
source/refill_pkg.sv
source/fetch_decode.sv
source/icache_lookup.sv
source/refill_request.sv
source/refill_assembler.sv
source/icache_refill_top.sv
testbench/tb_icache_refill.sv

// ==== Makefile ====
# Verilator flow for the instruction cache refill subsystem

VERILATOR ?= verilator
TOP       ?= tb_icache_refill
RTL_TOP   ?= icache_refill_top
FILES     ?= files.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIMFLAGS  ?=

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILES) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILES) --top-module $(TOP) --Mdir $(BUILD_DIR)

# The run passes only if the pass line shows up in the simulator output
sim: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIMFLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/icache_testdata.txt ====
// op value hit: F fetch at address, X flush, E drive en_i with value
// value and hit are hex; hit is the expected fetch_hit_o and is ignored for X and E
F 00001008 0
F 00001000 1
F 00001010 1
F 00001018 1
F 00001008 1
F 80000418 0
F 80000418 0
F 80000420 0
X 00000000 0
F 00001010 0
F 00001000 1
E 00000000 0
F 00001000 0
F 00001000 0
F 00000200 0
E 00000001 0
F 00001000 1
F 00000208 0
F 00000200 1
F 00002040 0
F 00003040 0
F 00002048 0
F 00003058 0
F 00003040 1
